//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module tb_snake_vga -f snake_vga.f -o Vtb_snake_vga
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

# assertion errors are collected by the testbench, which ends with \$fatal
./obj_dir/Vtb_snake_vga +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

//--- snake_vga.f
snake_vga_pkg.sv
vga_timing.sv
tile_map_writer.sv
tile_map.sv
sprite_rom.sv
tile_renderer.sv
snake_vga.sv
tb_snake_vga_assert.sv
tb_snake_vga.sv

//--- snake_vga.sv
`timescale 1ns/10ps

module snake_vga
  import snake_vga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       chipselect,
  input  logic       write,
  input  logic [2:0] address,
  input  logic [7:0] writedata,
  output logic       waitrequest,
  output logic [7:0] VGA_R,
  output logic [7:0] VGA_G,
  output logic [7:0] VGA_B,
  output logic       VGA_CLK,
  output logic       VGA_HS,
  output logic       VGA_VS,
  output logic       VGA_BLANK_n,
  output logic       VGA_SYNC_n
);

  host_bus_t              bus;
  vga_count_t             count;
  vga_sync_t              raw_sync;
  vga_sync_t              out_sync;
  map_write_t             map_wr;
  rgb_t                   background;
  rgb_t                   rgb;
  logic [MAP_AW-1:0]      map_addr;
  tile_kind_e             map_kind;
  logic [SPRITE_AW-1:0]   sprite_addr;
  logic [15:0]            sprite_pixel;

  // --------------------------------------------------------------------------
  // host side
  // --------------------------------------------------------------------------
  assign bus = '{chipselect: chipselect,
                 write:      write,
                 address:    reg_addr_e'(address),
                 writedata:  writedata};

  tile_map_writer tile_map_writer_inst (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus),
    .waitrequest(waitrequest),
    .map_wr     (map_wr),
    .background (background)
  );

  tile_map tile_map_inst (
    .clk    (clk),
    .map_wr (map_wr),
    .rd_addr(map_addr),
    .rd_kind(map_kind)
  );

  // --------------------------------------------------------------------------
  // video side
  // --------------------------------------------------------------------------
  vga_timing vga_timing_inst (
    .clk  (clk),
    .reset(reset),
    .count(count),
    .sync (raw_sync)
  );

  sprite_rom sprite_rom_inst (
    .clk  (clk),
    .addr (sprite_addr),
    .pixel(sprite_pixel)
  );

  tile_renderer tile_renderer_inst (
    .clk         (clk),
    .reset       (reset),
    .count       (count),
    .sync_in     (raw_sync),
    .background  (background),
    .map_addr    (map_addr),
    .map_kind    (map_kind),
    .sprite_addr (sprite_addr),
    .sprite_pixel(sprite_pixel),
    .rgb         (rgb),
    .sync_out    (out_sync)
  );

  // colour and sync leave together
  assign {VGA_R, VGA_G, VGA_B} = {rgb.r, rgb.g, rgb.b};
  assign VGA_CLK     = out_sync.pix_clk;
  assign VGA_HS      = out_sync.hs;
  assign VGA_VS      = out_sync.vs;
  assign VGA_BLANK_n = out_sync.blank_n;
  // no sync on green
  assign VGA_SYNC_n  = 1'b0;

endmodule

//--- snake_vga_pkg.sv
package snake_vga_pkg;

  // --------------------------------------------------------------------------
  // 640x480 timing, counted in 50 MHz clocks (two clocks per pixel)
  // --------------------------------------------------------------------------
  localparam logic [10:0] H_ACTIVE = 11'd1280;
  localparam logic [10:0] H_FRONT  = 11'd32;
  localparam logic [10:0] H_SYNC   = 11'd192;
  localparam logic [10:0] H_BACK   = 11'd96;
  localparam logic [10:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical, counted in lines
  localparam logic [9:0] V_ACTIVE = 10'd480;
  localparam logic [9:0] V_FRONT  = 10'd10;
  localparam logic [9:0] V_SYNC   = 10'd2;
  localparam logic [9:0] V_BACK   = 10'd33;
  localparam logic [9:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // --------------------------------------------------------------------------
  // tile grid and sprite geometry
  // --------------------------------------------------------------------------
  localparam int TILE_COLS    = 40;
  localparam int TILE_ROWS    = 30;
  localparam int COL_W        = 6;
  localparam int ROW_W        = 5;
  localparam int MAP_DEPTH    = TILE_COLS * TILE_ROWS;
  localparam int MAP_AW       = 11;
  localparam int TILE_PIX     = 16;
  localparam int TILE_OFF_W   = $clog2(TILE_PIX);
  localparam int SPRITE_W     = 8;
  localparam int SPRITE_NUM   = 3;
  localparam int SPRITE_DEPTH = SPRITE_NUM * SPRITE_W * SPRITE_W;
  localparam int SPRITE_AW    = 8;
  // counter to colour, in clocks
  localparam int PIPE_DEPTH   = 3;

  // tile code minus one selects the sprite
  typedef enum logic [1:0] {
    tile_empty = 2'd0,
    tile_apple = 2'd1,
    tile_head  = 2'd2,
    tile_wall  = 2'd3
  } tile_kind_e;

  // host register map
  typedef enum logic [2:0] {
    reg_col  = 3'd0,
    reg_row  = 3'd1,
    reg_tile = 3'd2,
    reg_bg_r = 3'd3,
    reg_bg_g = 3'd4,
    reg_bg_b = 3'd5
  } reg_addr_e;

  typedef struct packed {
    logic [10:0] hcount;
    logic [9:0]  vcount;
  } vga_count_t;

  // all active low except pix_clk
  typedef struct packed {
    logic pix_clk;
    logic hs;
    logic vs;
    logic blank_n;
  } vga_sync_t;

  // sync state while idle or out of reset
  localparam vga_sync_t SYNC_IDLE = '{pix_clk: 1'b0, hs: 1'b1, vs: 1'b1, blank_n: 1'b0};

  typedef struct packed {
    logic       chipselect;
    logic       write;
    reg_addr_e  address;
    logic [7:0] writedata;
  } host_bus_t;

  typedef struct packed {
    logic              en;
    logic [MAP_AW-1:0] addr;
    tile_kind_e        kind;
  } map_write_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // row-major tile address, row * 40 + col
  function automatic logic [MAP_AW-1:0] tile_index(input logic [COL_W-1:0] col,
                                                   input logic [ROW_W-1:0] row);
    logic [MAP_AW-1:0] row_ext;
    row_ext = MAP_AW'(row);
    return row_ext * MAP_AW'(TILE_COLS) + MAP_AW'(col);
  endfunction

endpackage

//--- sprite_rom.hex
// RGB565 sprite pixels, 8 words per line, one line per sprite row
// lines 1-8 apple, 9-16 snake head, 17-24 wall
0000 0000 0000 8220 2D05 2D05 0000 0000
0000 0000 0000 8220 2D05 0000 0000 0000
0000 E1A4 E1A4 E1A4 E1A4 E1A4 E1A4 0000
E1A4 E1A4 FE79 E1A4 E1A4 E1A4 E1A4 E1A4
E1A4 FE79 E1A4 E1A4 E1A4 E1A4 E1A4 E1A4
E1A4 E1A4 E1A4 E1A4 E1A4 E1A4 E1A4 E1A4
0000 E1A4 E1A4 E1A4 E1A4 E1A4 E1A4 0000
0000 0000 E1A4 E1A4 E1A4 E1A4 0000 0000
0000 4E89 4E89 4E89 4E89 4E89 4E89 0000
4E89 4E89 4E89 4E89 4E89 4E89 4E89 4E89
4E89 FFFF 0841 4E89 4E89 FFFF 0841 4E89
4E89 FFFF FFFF 4E89 4E89 FFFF FFFF 4E89
4E89 4E89 4E89 4E89 4E89 4E89 4E89 4E89
4E89 4E89 4E89 4E89 4E89 4E89 4E89 4E89
0000 4E89 4E89 D8C3 D8C3 4E89 4E89 0000
0000 0000 0000 D8C3 D8C3 0000 0000 0000
B3A6 B3A6 B3A6 8C71 B3A6 B3A6 B3A6 8C71
B3A6 B3A6 B3A6 8C71 B3A6 B3A6 B3A6 8C71
B3A6 B3A6 B3A6 8C71 B3A6 B3A6 B3A6 8C71
8C71 8C71 8C71 8C71 8C71 8C71 8C71 8C71
B3A6 8C71 B3A6 B3A6 B3A6 8C71 B3A6 B3A6
B3A6 8C71 B3A6 B3A6 B3A6 8C71 B3A6 B3A6
B3A6 8C71 B3A6 B3A6 B3A6 8C71 B3A6 B3A6
8C71 8C71 8C71 8C71 8C71 8C71 8C71 8C71

//--- sprite_rom.sv
`timescale 1ns/10ps

module sprite_rom
  import snake_vga_pkg::*;
(
  input  logic                 clk,
  input  logic [SPRITE_AW-1:0] addr,
  output logic [15:0]          pixel
);

  // 3 sprites of 8x8 RGB565
  // layout is sprite * 64 + row * 8 + col
  // apple, then head, then wall
  logic [15:0] rom [SPRITE_DEPTH];

  initial begin
    $readmemh("sprite_rom.hex", rom);
  end

  // --------------------------------------------------------------------------
  // registered read
  // --------------------------------------------------------------------------

  // address stays below SPRITE_DEPTH, renderer never asks for empty
  always_ff @(posedge clk) begin
    pixel <= rom[addr];
  end

endmodule

//--- tb_snake_vga.sv
`timescale 1ns/10ps

module tb_snake_vga
  import snake_vga_pkg::*;
();

  localparam int LINE_CLKS      = int'(H_TOTAL);
  localparam int FRAME_CLKS     = LINE_CLKS * int'(V_TOTAL);
  // sweep, one frame to wait out, one frame checked, a few lines spare
  localparam int TIMEOUT_CYCLES = MAP_DEPTH + 2 * FRAME_CLKS + 10 * LINE_CLKS;
  localparam int FRAME_CHECKS   = int'(H_ACTIVE) * int'(V_ACTIVE);

  logic       clk = 1'b0;
  logic       reset;
  logic       chipselect;
  logic       write;
  logic [2:0] address;
  logic [7:0] writedata;
  logic       waitrequest;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic       vga_clk;
  logic       vga_hs;
  logic       vga_vs;
  logic       vga_blank_n;
  logic       vga_sync_n;

  // reference state
  logic [15:0] rom_model [SPRITE_DEPTH];
  int          map_model [TILE_ROWS][TILE_COLS];
  rgb_t        bg_model;
  int          cycles         = 0;
  int          edge_count     = 0;
  int          pixels_checked = 0;
  int          vs_rises       = 0;
  logic        vs_last        = 1'b1;
  int          cur_x;
  int          cur_y;

  always #5 clk = ~clk;

  snake_vga snake_vga_inst (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .waitrequest(waitrequest),
    .VGA_R      (vga_r),
    .VGA_G      (vga_g),
    .VGA_B      (vga_b),
    .VGA_CLK    (vga_clk),
    .VGA_HS     (vga_hs),
    .VGA_VS     (vga_vs),
    .VGA_BLANK_n(vga_blank_n),
    .VGA_SYNC_n (vga_sync_n)
  );

  // bus and sync checker inside the DUT scope
  bind snake_vga tb_snake_vga_assert assert_inst (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .write      (write),
    .waitrequest(waitrequest),
    .vga_r      (VGA_R),
    .vga_g      (VGA_G),
    .vga_b      (VGA_B),
    .vga_hs     (VGA_HS),
    .vga_vs     (VGA_VS),
    .vga_blank_n(VGA_BLANK_n)
  );

  // --------------------------------------------------------------------------
  // failure reporting
  // --------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("CHECK FAILED %s at pixel (%0d,%0d): expected 0x%0h, actual 0x%0h",
                        test, cur_x, cur_y, exp, act));
  endtask

  // --------------------------------------------------------------------------
  // reference pixel model
  // --------------------------------------------------------------------------

  // border forces wall, empty shows background, sprites doubled 2x2
  function automatic rgb_t model_colour(input int px, input int py, output string test);
    int          col;
    int          row;
    int          kind;
    logic [15:0] p;
    col = px / TILE_PIX;
    row = py / TILE_PIX;
    if (col == 0 || col == TILE_COLS - 1 || row == 0 || row == TILE_ROWS - 1) begin
      kind = int'(tile_wall);
      test = "border";
    end else begin
      kind = map_model[row][col];
      test = (kind == int'(tile_empty)) ? "background" : "sprite";
    end
    if (kind == int'(tile_empty)) begin
      return bg_model;
    end
    p = rom_model[(kind - 1) * SPRITE_W * SPRITE_W + ((py % TILE_PIX) / 2) * SPRITE_W +
                  (px % TILE_PIX) / 2];
    // RGB565 widened with zero fill
    return '{r: {p[15:11], 3'b000}, g: {p[10:5], 2'b00}, b: {p[4:0], 3'b000}};
  endfunction

  // t counts clocks from reset release already shifted by the pipeline
  task automatic check_pixel(input int t);
    int    h;
    int    v;
    logic  exp_blank;
    logic  exp_clk;
    rgb_t  exp_rgb;
    rgb_t  act_rgb;
    string test;
    h = t % LINE_CLKS;
    v = (t / LINE_CLKS) % int'(V_TOTAL);
    cur_x = h / 2;
    cur_y = v;
    exp_blank = (h < int'(H_ACTIVE)) && (v < int'(V_ACTIVE));
    // pixel clock is hcount bit 0
    exp_clk = 1'(h % 2);
    assert (vga_blank_n == exp_blank)
      else value_error("blank", 32'(exp_blank), 32'(vga_blank_n));
    assert (vga_clk == exp_clk)
      else value_error("pixel clock", 32'(exp_clk), 32'(vga_clk));
    // sync on green stays off
    assert (vga_sync_n == 1'b0)
      else value_error("sync on green", 32'd0, 32'(vga_sync_n));
    // colour over the first whole frame after the host writes
    if (exp_blank && t / FRAME_CLKS == 1) begin
      exp_rgb = model_colour(cur_x, cur_y, test);
      act_rgb = '{r: vga_r, g: vga_g, b: vga_b};
      assert (act_rgb == exp_rgb)
        else value_error(test, 32'(exp_rgb), 32'(act_rgb));
      pixels_checked++;
    end
  endtask

  // --------------------------------------------------------------------------
  // host bus
  // --------------------------------------------------------------------------

  // one write that the DUT takes on the next edge
  task automatic host_write(input reg_addr_e addr, input logic [7:0] data);
    chipselect <= 1'b1;
    write      <= 1'b1;
    address    <= addr;
    writedata  <= data;
    @(posedge clk);
    chipselect <= 1'b0;
    write      <= 1'b0;
  endtask

  task automatic place_tile(input int col, input int row, input tile_kind_e kind);
    host_write(reg_col, 8'(col));
    host_write(reg_row, 8'(row));
    host_write(reg_tile, 8'(kind));
    map_model[row][col] = int'(kind);
  endtask

  task automatic set_background(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
    host_write(reg_bg_r, r);
    host_write(reg_bg_g, g);
    host_write(reg_bg_b, b);
    bg_model = '{r: r, g: g, b: b};
  endtask

  // --------------------------------------------------------------------------
  // cycle count, timeout and output sampling
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (!reset) begin
      edge_count++;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles without finishing frame", cycles));
    end
  end

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    if (vga_vs && !vs_last) begin
      vs_rises++;
    end
    vs_last = vga_vs;
    if (edge_count >= PIPE_DEPTH) begin
      check_pixel(edge_count - PIPE_DEPTH);
    end
    if (snake_vga_inst.assert_inst.failures != 0) begin
      abort_run("a bound assertion on snake_vga failed, see the error above");
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    reset      = 1'b1;
    chipselect = 1'b0;
    write      = 1'b0;
    address    = '0;
    writedata  = '0;
    bg_model   = '0;
    $readmemh("sprite_rom.hex", rom_model);
    foreach (map_model[r, c]) begin
      map_model[r][c] = int'(tile_empty);
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // wait out the clear sweep
    while (waitrequest) begin
      @(posedge clk);
    end
    set_background(8'h12, 8'h34, 8'h56);
    place_tile(5, 4, tile_apple);
    place_tile(10, 10, tile_head);
    place_tile(20, 15, tile_apple);
    place_tile(20, 15, tile_empty);
    // Walls must win over whatever the map holds.
    place_tile(0, 7, tile_apple);
    // second vsync ends after the checked frame
    while (vs_rises < 2) begin
      @(posedge clk);
    end
    // two more edges for the bound width and period checks
    repeat (2) @(posedge clk);
    assert (pixels_checked == FRAME_CHECKS)
      else value_error("coverage", 32'(FRAME_CHECKS), 32'(pixels_checked));
    if (snake_vga_inst.assert_inst.failures != 0) begin
      abort_run("bound assertions reported failures");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

//--- tb_snake_vga_assert.sv
`timescale 1ns/10ps

module tb_snake_vga_assert
  import snake_vga_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       chipselect,
  input logic       write,
  input logic       waitrequest,
  input logic [7:0] vga_r,
  input logic [7:0] vga_g,
  input logic [7:0] vga_b,
  input logic       vga_hs,
  input logic       vga_vs,
  input logic       vga_blank_n
);

  localparam int SWEEP_CLKS = MAP_DEPTH;
  localparam int LINE_CLKS  = int'(H_TOTAL);
  localparam int FRAME_CLKS = LINE_CLKS * int'(V_TOTAL);
  localparam int HS_LOW     = int'(H_SYNC);
  // vsync spans whole lines
  localparam int VS_LOW     = int'(V_SYNC) * LINE_CLKS;

  int   since_reset;
  int   hs_low_len;
  int   hs_period;
  int   vs_low_len;
  int   vs_period;
  logic hs_prev;
  logic vs_prev;
  logic hs_armed;
  logic vs_armed;

  // failure counts, one per property
  int   sweep_errs = 0;
  int   host_errs  = 0;
  int   hs_errs    = 0;
  int   vs_errs    = 0;
  int   blank_errs = 0;
  int   failures;

  assign failures = sweep_errs + host_errs + hs_errs + vs_errs + blank_errs;

  // --------------------------------------------------------------------------
  // cycle and pulse counters
  // --------------------------------------------------------------------------

  // clocks since reset release, saturates past the sweep
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      since_reset <= 0;
    end else if (since_reset <= SWEEP_CLKS) begin
      since_reset <= since_reset + 1;
    end
  end

  // low run length and fall-to-fall distance of both syncs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hs_prev    <= 1'b1;
      vs_prev    <= 1'b1;
      hs_armed   <= 1'b0;
      vs_armed   <= 1'b0;
      hs_low_len <= 0;
      vs_low_len <= 0;
      hs_period  <= 0;
      vs_period  <= 0;
    end else begin
      hs_prev    <= vga_hs;
      vs_prev    <= vga_vs;
      hs_low_len <= vga_hs ? 0 : hs_low_len + 1;
      vs_low_len <= vga_vs ? 0 : vs_low_len + 1;
      // first fall only arms the period check
      if (hs_prev && !vga_hs) begin
        hs_period <= 1;
        hs_armed  <= 1'b1;
      end else begin
        hs_period <= hs_period + 1;
      end
      if (vs_prev && !vga_vs) begin
        vs_period <= 1;
        vs_armed  <= 1'b1;
      end else begin
        vs_period <= vs_period + 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // properties
  // --------------------------------------------------------------------------

  // host held off for exactly the clear sweep
  sweep_length: assert property (@(posedge clk) disable iff (reset)
    waitrequest == (since_reset < SWEEP_CLKS))
    else begin
      $error("waitrequest does not span exactly the clear sweep");
      sweep_errs++;
    end

  host_waits: assert property (@(posedge clk) disable iff (reset)
    (chipselect && write) |-> !waitrequest)
    else begin
      $error("host wrote while waitrequest was high");
      host_errs++;
    end

  hs_width: assert property (@(posedge clk) disable iff (reset)
    (!hs_prev && vga_hs) |-> hs_low_len == HS_LOW)
    else begin
      $error("hsync pulse width is %0d clocks", hs_low_len);
      hs_errs++;
    end

  hs_line: assert property (@(posedge clk) disable iff (reset)
    (hs_prev && !vga_hs && hs_armed) |-> hs_period == LINE_CLKS)
    else begin
      $error("hsync period is %0d clocks", hs_period);
      hs_errs++;
    end

  vs_width: assert property (@(posedge clk) disable iff (reset)
    (!vs_prev && vga_vs) |-> vs_low_len == VS_LOW)
    else begin
      $error("vsync pulse width is %0d clocks", vs_low_len);
      vs_errs++;
    end

  vs_frame: assert property (@(posedge clk) disable iff (reset)
    (vs_prev && !vga_vs && vs_armed) |-> vs_period == FRAME_CLKS)
    else begin
      $error("vsync period is %0d clocks", vs_period);
      vs_errs++;
    end

  // Colour must be black outside the visible window.
  blank_black: assert property (@(posedge clk) disable iff (reset)
    !vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'd0)
    else begin
      $error("colour is not zero while blanked");
      blank_errs++;
    end

endmodule

//--- tile_map.sv
`timescale 1ns/10ps

module tile_map
  import snake_vga_pkg::*;
(
  input  logic              clk,
  input  map_write_t        map_wr,
  input  logic [MAP_AW-1:0] rd_addr,
  output tile_kind_e        rd_kind
);

  // one entry per tile, row major
  tile_kind_e mem [MAP_DEPTH];

  // --------------------------------------------------------------------------
  // write port, from the writer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (map_wr.en) begin
      mem[map_wr.addr] <= map_wr.kind;
    end
  end

  // --------------------------------------------------------------------------
  // read port, one clock latency
  // --------------------------------------------------------------------------

  // renderer only asks for in-grid tiles
  always_ff @(posedge clk) begin
    rd_kind <= mem[rd_addr];
  end

endmodule

//--- tile_map_writer.sv
`timescale 1ns/10ps

module tile_map_writer
  import snake_vga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  host_bus_t  bus,
  output logic       waitrequest,
  output map_write_t map_wr,
  output rgb_t       background
);

  typedef enum logic {
    clearing,
    ready
  } writer_state_e;

  writer_state_e     state;
  logic [MAP_AW-1:0] sweep_cnt;
  logic              sweep_last;
  logic [7:0]        col_q;
  logic [7:0]        row_q;
  logic              cursor_in_grid;
  logic              bus_write;

  // --------------------------------------------------------------------------
  // clear sweep after reset
  // --------------------------------------------------------------------------
  assign sweep_last  = sweep_cnt == MAP_AW'(MAP_DEPTH - 1);
  // host held off for the whole sweep
  assign waitrequest = state == clearing;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= clearing;
      sweep_cnt <= '0;
    end else if (state == clearing) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_last) begin
        state <= ready;
      end
    end
  end

  // --------------------------------------------------------------------------
  // register decode
  // --------------------------------------------------------------------------
  // write accepted only once the sweep is done
  assign bus_write      = bus.chipselect && bus.write && (state == ready);
  assign cursor_in_grid = (col_q < TILE_COLS) && (row_q < TILE_ROWS);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col_q      <= '0;
      row_q      <= '0;
      background <= '0;
    end else if (bus_write) begin
      case (bus.address)
        reg_col:  col_q <= bus.writedata;
        reg_row:  row_q <= bus.writedata;
        reg_bg_r: background.r <= bus.writedata;
        reg_bg_g: background.g <= bus.writedata;
        reg_bg_b: background.b <= bus.writedata;
        default:  ;
      endcase
    end
  end

  // map write port, registered; sweep has priority over the host
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      map_wr <= '0;
    end else if (state == clearing) begin
      map_wr <= '{en: 1'b1, addr: sweep_cnt, kind: tile_empty};
    end else if (bus_write && bus.address == reg_tile) begin
      // off-grid cursor drops the write
      map_wr <= '{en:   cursor_in_grid,
                  addr: tile_index(col_q[COL_W-1:0], row_q[ROW_W-1:0]),
                  kind: tile_kind_e'(bus.writedata[1:0])};
    end else begin
      map_wr.en <= 1'b0;
    end
  end

endmodule

//--- tile_renderer.sv
`timescale 1ns/10ps

module tile_renderer
  import snake_vga_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  vga_count_t           count,
  input  vga_sync_t            sync_in,
  input  rgb_t                 background,
  output logic [MAP_AW-1:0]    map_addr,
  input  tile_kind_e           map_kind,
  output logic [SPRITE_AW-1:0] sprite_addr,
  input  logic [15:0]          sprite_pixel,
  output rgb_t                 rgb,
  output vga_sync_t            sync_out
);

  // pixel position, hcount halved
  logic [9:0]              pix_x;
  logic [9:0]              pix_y;
  logic [9-TILE_OFF_W:0]   tile_col;
  logic [9-TILE_OFF_W:0]   tile_row;
  logic                    in_grid;
  logic                    on_border;

  // stage 1 registers
  logic                    s1_border;
  logic [TILE_OFF_W-1:0]   s1_off_x;
  logic [TILE_OFF_W-1:0]   s1_off_y;

  // stage 2
  tile_kind_e              s2_kind;
  logic [1:0]              s2_sprite;
  logic                    s2_bg;
  rgb_t                    sprite_rgb;

  // sync delay line, one entry per stage
  vga_sync_t               sync_pipe [PIPE_DEPTH];

  // --------------------------------------------------------------------------
  // stage 1: tile lookup
  // --------------------------------------------------------------------------
  assign pix_x    = count.hcount[10:1];
  assign pix_y    = count.vcount;
  assign tile_col = pix_x[9:TILE_OFF_W];
  assign tile_row = pix_y[9:TILE_OFF_W];

  // blanking area falls outside the grid
  assign in_grid   = (tile_col < TILE_COLS) && (tile_row < TILE_ROWS);
  assign on_border = in_grid && (tile_col == 0 || tile_col == TILE_COLS - 1 ||
                                 tile_row == 0 || tile_row == TILE_ROWS - 1);

  // off-grid reads go to tile 0, result unused
  assign map_addr = in_grid ?
                    tile_index(tile_col[COL_W-1:0], tile_row[ROW_W-1:0]) : '0;

  always_ff @(posedge clk) begin
    s1_border <= on_border;
    s1_off_x  <= pix_x[TILE_OFF_W-1:0];
    s1_off_y  <= pix_y[TILE_OFF_W-1:0];
  end

  // --------------------------------------------------------------------------
  // stage 2: kind select and sprite fetch
  // --------------------------------------------------------------------------
  // border overrides whatever the map holds
  assign s2_kind   = s1_border ? tile_wall : map_kind;
  assign s2_sprite = s2_kind - 2'd1;

  // each sprite pixel covers 2x2 screen pixels
  assign sprite_addr = (s2_kind == tile_empty) ? '0 :
                       {s2_sprite, s1_off_y[TILE_OFF_W-1:1], s1_off_x[TILE_OFF_W-1:1]};

  always_ff @(posedge clk) begin
    s2_bg <= s2_kind == tile_empty;
  end

  // --------------------------------------------------------------------------
  // stage 3: colour out
  // --------------------------------------------------------------------------

  // RGB565 widened with zero fill
  assign sprite_rgb = '{r: {sprite_pixel[15:11], 3'b000},
                        g: {sprite_pixel[10:5],  2'b00},
                        b: {sprite_pixel[4:0],   3'b000}};

  // blank_n taken one stage early so it lines up with rgb
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb <= '0;
    end else if (!sync_pipe[PIPE_DEPTH-2].blank_n) begin
      rgb <= '0;
    end else if (s2_bg) begin
      rgb <= background;
    end else begin
      rgb <= sprite_rgb;
    end
  end

  // sync follows colour by the same PIPE_DEPTH clocks
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        sync_pipe[i] <= SYNC_IDLE;
      end
    end else begin
      sync_pipe[0] <= sync_in;
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        sync_pipe[i] <= sync_pipe[i-1];
      end
    end
  end

  assign sync_out = sync_pipe[PIPE_DEPTH-1];

endmodule

//--- vga_timing.sv
`timescale 1ns/10ps

module vga_timing
  import snake_vga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  output vga_count_t count,
  output vga_sync_t  sync
);

  logic end_of_line;
  logic end_of_field;
  logic hs_active;
  logic vs_active;

  // --------------------------------------------------------------------------
  // line and field counters
  // --------------------------------------------------------------------------

  // last clock of the line, 1599
  assign end_of_line  = count.hcount == H_TOTAL - 11'd1;
  // last line of the field, 524
  assign end_of_field = count.vcount == V_TOTAL - 10'd1;

  // hcount runs every clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count.hcount <= '0;
    end else if (end_of_line) begin
      count.hcount <= '0;
    end else begin
      count.hcount <= count.hcount + 11'd1;
    end
  end

  // vcount steps once per line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count.vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_field) begin
        count.vcount <= '0;
      end else begin
        count.vcount <= count.vcount + 10'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // sync and blank decode
  // --------------------------------------------------------------------------

  // hsync pulse after front porch, 1312 to 1503
  assign hs_active = (count.hcount >= H_ACTIVE + H_FRONT) &&
                     (count.hcount <  H_ACTIVE + H_FRONT + H_SYNC);

  // vsync pulse on lines 490 and 491
  assign vs_active = (count.vcount >= V_ACTIVE + V_FRONT) &&
                     (count.vcount <  V_ACTIVE + V_FRONT + V_SYNC);

  assign sync.hs      = !hs_active;
  assign sync.vs      = !vs_active;
  // visible only inside both active windows
  assign sync.blank_n = (count.hcount < H_ACTIVE) && (count.vcount < V_ACTIVE);
  // 25 MHz pixel clock, rising edge mid-pixel
  assign sync.pix_clk = count.hcount[0];

endmodule
